//--- verif/fmul_patterns.txt
# operand_a operand_b rounding_mode expected_result expected_flags, all hex
# flags are invalid, overflow, underflow, inexact from the top bit down
3f800000 3f800000 0 3f800000 0
40000000 40400000 0 40c00000 0
3f800001 3f800001 0 3f800002 1
3f800001 3f800001 1 3f800002 1
3f800001 3f800001 2 3f800002 1
3f800001 3f800001 3 3f800003 1
3f800001 3f800001 4 3f800002 1
bf800001 3f800001 2 bf800003 1
bf800001 3f800001 3 bf800002 1
3f800800 3f800800 0 3f801000 1
3f800800 3f800800 4 3f801001 1
3fc00000 3f800001 0 3fc00002 1
3fc00000 3f800001 1 3fc00001 1
3fc00000 3f800001 7 3fc00002 1
3fb504f3 3fb504f3 0 3fffffff 1
3fb504f3 3fb504f3 3 40000000 1
7fc12345 3f800000 0 7fc00000 0
7f800001 3f800000 0 7fc00000 8
ffc00000 7f800001 1 7fc00000 8
7f800000 00000000 0 7fc00000 8
80000000 ff800000 2 7fc00000 8
7f800000 c0000000 0 ff800000 0
80000000 40400000 0 80000000 0
00000000 c0000000 3 80000000 0
7f000000 40000000 0 7f800000 5
7f000000 40000000 1 7f7fffff 5
7f000000 40000000 2 7f7fffff 5
7f000000 40000000 3 7f800000 5
7f000000 40000000 4 7f800000 5
ff000000 40000000 2 ff800000 5
ff000000 40000000 3 ff7fffff 5
00800000 3f000000 0 00000000 3
80800000 3f000000 2 80000000 3
00000001 40000000 0 00000000 0
807fffff 3f800000 0 80000000 0
00400000 7f800000 0 7fc00000 8

//--- files.f
src/fmul_pkg.sv
src/fmul_decode.sv
src/fmul_execute.sv
src/fmul_result.sv
src/fmul_top.sv
verif/fmul_properties.sv
verif/fmul_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f files.f --top-module fmul_tb -Mdir obj_dir -o fmul_sim
	-./obj_dir/fmul_sim > sim.log 2>&1
	@cat sim.log
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/fmul_tb.sv
module fmul_tb;

  logic             clk;
  logic             rst;
  logic             req;
  fmul_pkg::fp_t    operand_a;
  fmul_pkg::fp_t    operand_b;
  fmul_pkg::rm_t    rounding_mode;
  logic             ack;
  fmul_pkg::fp_t    result;
  fmul_pkg::flags_t flags;

  // One entry per pattern line
  fmul_pkg::fp_t    pat_a[$];
  fmul_pkg::fp_t    pat_b[$];
  fmul_pkg::rm_t    pat_rm[$];
  fmul_pkg::fp_t    pat_result[$];
  fmul_pkg::flags_t pat_flags[$];

  logic [31:0]      rng_state;
  int unsigned      cycle_count;
  int unsigned      cycle_limit;
  logic             limit_set = 1'b0;

  fmul_top dut0 (
    .i_clk           (clk),
    .i_rst           (rst),
    .i_req           (req),
    .i_operand_a     (operand_a),
    .i_operand_b     (operand_b),
    .i_rounding_mode (rounding_mode),
    .o_ack           (ack),
    .o_result        (result),
    .o_flags         (flags)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ========================================================================
  // Helpers
  // ========================================================================

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAIL %0t: %s is %08h, expected %08h", $time, what, actual, expected);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // Lines that do not hold five hex fields are skipped as comments
  task automatic load_patterns();
    int                   fd;
    int                   code;
    fmul_pkg::fp_t        a;
    fmul_pkg::fp_t        b;
    fmul_pkg::rm_t        rm;
    fmul_pkg::fp_t        res;
    fmul_pkg::flags_t     fl;
    logic [8*128-1:0]     skipped;
    fd = $fopen("verif/fmul_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file verif/fmul_patterns.txt");
      $display("sim failed");
      $fatal(1);
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%h %h %h %h %h", a, b, rm, res, fl);
        if (code == 5) begin
          pat_a.push_back(a);
          pat_b.push_back(b);
          pat_rm.push_back(rm);
          pat_result.push_back(res);
          pat_flags.push_back(fl);
        end else if (code >= 0) begin
          code = $fgets(skipped, fd);
        end
      end
      $fclose(fd);
    end
  endtask

  // Full req/ack cycle for one pattern driven on falling edges
  task automatic run_pattern(input int idx, input int unsigned hold);
    int unsigned waited;
    string       tag;
    tag = $sformatf("pattern %0d", idx);
    operand_a = pat_a[idx];
    operand_b = pat_b[idx];
    rounding_mode = pat_rm[idx];
    req = 1'b1;
    waited = 0;
    while (!ack) begin
      @(negedge clk);
      waited++;
    end
    // Capture edge is the first rising edge after req went up
    check_value(waited - 1, 32'd5, {tag, " ack latency after capture"});
    check_value(result, pat_result[idx], {tag, " result"});
    check_value(32'(flags), 32'(pat_flags[idx]), {tag, " flags"});
    // A req held past ack keeps ack high
    repeat (hold) begin
      @(negedge clk);
      check_value(32'(ack), 32'd1, {tag, " ack while req held"});
    end
    req = 1'b0;
    // Ack drops at the first edge that sees req low
    @(negedge clk);
    check_value(32'(ack), 32'd0, {tag, " ack after req low"});
  endtask

  // ========================================================================
  // Main sequence
  // ========================================================================

  initial begin
    rst = 1'b1;
    req = 1'b0;
    operand_a = '0;
    operand_b = '0;
    rounding_mode = '0;
    rng_state = 32'd54259;
    load_patterns();
    cycle_limit = 20 * pat_a.size() + 16;
    limit_set = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < pat_a.size(); i++) begin
      // Req stays up 0 to 3 cycles past ack
      rng_state = next_random(rng_state);
      run_pattern(i, rng_state % 4);
      // Idle gap of 0 to 3 cycles before the next request
      rng_state = next_random(rng_state);
      repeat (rng_state % 4) @(negedge clk);
    end
    if (pat_a.size() > 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("no patterns were read from the pattern file");
      $display("sim failed");
      $fatal(1);
    end
  end

  // Watchdog sized from the number of patterns
  initial begin
    cycle_count = 0;
    wait (limit_set);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles before all patterns finished", cycle_count);
    $display("sim failed");
    $fatal(1);
  end

endmodule

//--- verif/fmul_properties.sv
module fmul_properties (
  input logic             i_clk,
  input logic             i_rst,
  input logic             i_req,
  input logic             i_ack,
  input fmul_pkg::fp_t    i_result,
  input fmul_pkg::flags_t i_flags
);

  // Ack only answers a request that was up at the rising edge
  ack_rise_needs_req: assert property (
    @(posedge i_clk) disable iff (i_rst) $rose(i_ack) |-> $past(i_req)
  ) else $error("ack rose while req was low");

  // Ack drops only once req has been seen low
  ack_fall_after_req_low: assert property (
    @(posedge i_clk) disable iff (i_rst) $fell(i_ack) |-> !$past(i_req)
  ) else $error("ack fell while req was still high");

  // Result and flags hold for the whole ack window
  result_stable_in_ack: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_ack |-> ($stable(i_result) && $stable(i_flags))
  ) else $error("result or flags changed while ack was high");

  // First cycle out of reset
  ack_low_after_reset: assert property (
    @(posedge i_clk) $fell(i_rst) |-> !i_ack
  ) else $error("ack high right after reset");

endmodule

bind fmul_top fmul_properties u_properties (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .i_req    (i_req),
  .i_ack    (o_ack),
  .i_result (o_result),
  .i_flags  (o_flags)
);

//--- src/fmul_top.sv
module fmul_top (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_req,
  input  fmul_pkg::fp_t    i_operand_a,
  input  fmul_pkg::fp_t    i_operand_b,
  input  fmul_pkg::rm_t    i_rounding_mode,
  output logic             o_ack,
  output fmul_pkg::fp_t    o_result,
  output fmul_pkg::flags_t o_flags
);

  typedef enum logic [2:0] {
    IDLE,
    DECODE,
    MULTIPLY,
    ROUND,
    FORMAT,
    DONE
  } state_e;

  state_e           state;
  state_e           next_state;
  logic             ack_q;
  fmul_pkg::fp_t    op_a_q;
  fmul_pkg::fp_t    op_b_q;
  fmul_pkg::rm_t    rm_q;
  logic             load_decode;
  logic             load_execute;
  logic             load_round;
  logic             load_format;
  logic             dec_sign;
  fmul_pkg::sexp_t  dec_exp;
  fmul_pkg::mant_t  dec_mant_a;
  fmul_pkg::mant_t  dec_mant_b;
  logic             dec_special;
  fmul_pkg::fp_t    dec_special_result;
  logic             dec_special_invalid;
  fmul_pkg::mant_t  exe_mant;
  fmul_pkg::sexp_t  exe_exp;
  logic             exe_guard;
  logic             exe_sticky;
  logic             res_sign;
  fmul_pkg::rm_t    res_rm;
  logic             res_special;
  fmul_pkg::fp_t    res_special_result;
  logic             res_special_invalid;

  // ========================================================================
  // Control FSM and req/ack handshake
  // ========================================================================

  always_comb begin
    next_state = state;
    case (state)
      IDLE:     if (i_req) next_state = DECODE;
      DECODE:   next_state = MULTIPLY;
      MULTIPLY: next_state = ROUND;
      ROUND:    next_state = FORMAT;
      FORMAT:   next_state = DONE;
      // Leave once ack is up and the requester has dropped req
      DONE:     if (ack_q && !i_req) next_state = IDLE;
      default:  next_state = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= IDLE;
      ack_q <= 1'b0;
    end else begin
      state <= next_state;
      if (state == DONE) begin
        // Raise one cycle after formatting, drop on the first low req
        if (!ack_q) begin
          ack_q <= 1'b1;
        end else if (!i_req) begin
          ack_q <= 1'b0;
        end
      end
    end
  end

  assign o_ack = ack_q;

  // One strobe per stage, one cycle each
  assign load_decode = (state == DECODE);
  assign load_execute = (state == MULTIPLY);
  assign load_round = (state == ROUND);
  assign load_format = (state == FORMAT);

  // Operand capture at the accepting edge
  always_ff @(posedge i_clk) begin
    if (state == IDLE && i_req) begin
      op_a_q <= i_operand_a;
      op_b_q <= i_operand_b;
      rm_q <= i_rounding_mode;
    end
  end

  // Sign, mode and special fields move alongside the product
  always_ff @(posedge i_clk) begin
    if (load_execute) begin
      res_sign <= dec_sign;
      res_rm <= rm_q;
      res_special <= dec_special;
      res_special_result <= dec_special_result;
      res_special_invalid <= dec_special_invalid;
    end
  end

  // ========================================================================
  // Stages
  // ========================================================================

  fmul_decode u_decode (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_load            (load_decode),
    .i_op_a            (op_a_q),
    .i_op_b            (op_b_q),
    .o_sign            (dec_sign),
    .o_exp             (dec_exp),
    .o_mant_a          (dec_mant_a),
    .o_mant_b          (dec_mant_b),
    .o_special         (dec_special),
    .o_special_result  (dec_special_result),
    .o_special_invalid (dec_special_invalid)
  );

  fmul_execute u_execute (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_load   (load_execute),
    .i_mant_a (dec_mant_a),
    .i_mant_b (dec_mant_b),
    .i_exp    (dec_exp),
    .o_mant   (exe_mant),
    .o_exp    (exe_exp),
    .o_guard  (exe_guard),
    .o_sticky (exe_sticky)
  );

  fmul_result u_result (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_round_load      (load_round),
    .i_format_load     (load_format),
    .i_sign            (res_sign),
    .i_rm              (res_rm),
    .i_mant            (exe_mant),
    .i_exp             (exe_exp),
    .i_guard           (exe_guard),
    .i_sticky          (exe_sticky),
    .i_special         (res_special),
    .i_special_result  (res_special_result),
    .i_special_invalid (res_special_invalid),
    .o_result          (o_result),
    .o_flags           (o_flags)
  );

endmodule

//--- src/fmul_result.sv
module fmul_result (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_round_load,
  input  logic             i_format_load,
  input  logic             i_sign,
  input  fmul_pkg::rm_t    i_rm,
  input  fmul_pkg::mant_t  i_mant,
  input  fmul_pkg::sexp_t  i_exp,
  input  logic             i_guard,
  input  logic             i_sticky,
  input  logic             i_special,
  input  fmul_pkg::fp_t    i_special_result,
  input  logic             i_special_invalid,
  output fmul_pkg::fp_t    o_result,
  output fmul_pkg::flags_t o_flags
);

  logic                        inexact;
  logic                        rne_up;
  logic                        round_up;
  logic                        round_up_q;
  logic                        inexact_q;
  logic [fmul_pkg::MANT_BITS:0] rounded;
  logic                        carry;
  fmul_pkg::sexp_t             adj_exp;
  fmul_pkg::frac_t             frac;
  logic                        overflow;
  logic                        underflow;
  fmul_pkg::fp_t               result;
  fmul_pkg::flags_t            flags;

  // ========================================================================
  // Round decision
  // ========================================================================

  assign inexact = i_guard | i_sticky;
  // Ties go to the even mantissa
  assign rne_up = i_guard & (i_sticky | i_mant[0]);

  always_comb begin
    case (i_rm)
      fmul_pkg::RM_RNE: round_up = rne_up;
      fmul_pkg::RM_RTZ: round_up = 1'b0;
      fmul_pkg::RM_RDN: round_up = inexact & i_sign;
      fmul_pkg::RM_RUP: round_up = inexact & ~i_sign;
      // Ties away from zero
      fmul_pkg::RM_RMM: round_up = i_guard;
      default: round_up = rne_up;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_round_load) begin
      round_up_q <= round_up;
      inexact_q <= inexact;
    end
  end

  // ========================================================================
  // Increment and format
  // ========================================================================

  assign rounded = {1'b0, i_mant} + {{fmul_pkg::MANT_BITS{1'b0}}, round_up_q};
  // Carry out means the mantissa wrapped to 1.0 of the next binade
  assign carry = rounded[fmul_pkg::MANT_BITS];
  assign adj_exp = carry ? i_exp + fmul_pkg::sexp_t'(1) : i_exp;
  // A carry leaves the stored fraction bits all zero
  assign frac = rounded[fmul_pkg::FRAC_BITS-1:0];

  assign overflow = (adj_exp >= fmul_pkg::sexp_t'({2'b00, fmul_pkg::EXP_MAX}));
  // No subnormal results so anything at or below zero flushes
  assign underflow = (adj_exp <= fmul_pkg::sexp_t'(0));

  always_comb begin
    result = '0;
    flags = '0;
    if (i_special) begin
      result = i_special_result;
      flags[fmul_pkg::FLAG_NV] = i_special_invalid;
    end else if (overflow) begin
      flags[fmul_pkg::FLAG_OF] = 1'b1;
      flags[fmul_pkg::FLAG_NX] = 1'b1;
      // Modes rounding toward zero for this sign stop at the largest finite
      if ((i_rm == fmul_pkg::RM_RTZ) ||
          (i_rm == fmul_pkg::RM_RDN && !i_sign) ||
          (i_rm == fmul_pkg::RM_RUP && i_sign)) begin
        result = {i_sign, fmul_pkg::exp_t'(fmul_pkg::EXP_MAX - 1), {fmul_pkg::FRAC_BITS{1'b1}}};
      end else begin
        result = {i_sign, fmul_pkg::EXP_MAX, {fmul_pkg::FRAC_BITS{1'b0}}};
      end
    end else if (underflow) begin
      flags[fmul_pkg::FLAG_UF] = 1'b1;
      flags[fmul_pkg::FLAG_NX] = 1'b1;
      result = {i_sign, {(fmul_pkg::EXP_BITS + fmul_pkg::FRAC_BITS){1'b0}}};
    end else begin
      flags[fmul_pkg::FLAG_NX] = inexact_q;
      result = {i_sign, adj_exp[fmul_pkg::EXP_BITS-1:0], frac};
    end
  end

  // Output register holds until the next format strobe
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_result <= '0;
      o_flags <= '0;
    end else if (i_format_load) begin
      o_result <= result;
      o_flags <= flags;
    end
  end

endmodule

//--- src/fmul_execute.sv
module fmul_execute (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_load,
  input  fmul_pkg::mant_t i_mant_a,
  input  fmul_pkg::mant_t i_mant_b,
  input  fmul_pkg::sexp_t i_exp,
  output fmul_pkg::mant_t o_mant,
  output fmul_pkg::sexp_t o_exp,
  output logic            o_guard,
  output logic            o_sticky
);

  fmul_pkg::prod_t product;
  fmul_pkg::prod_t norm;
  logic            top_set;

  // Both mantissas have the hidden bit, so the product is in [1, 4)
  assign product = fmul_pkg::prod_t'(i_mant_a) * fmul_pkg::prod_t'(i_mant_b);
  assign top_set = product[fmul_pkg::PROD_BITS-1];

  // One bit of normalization at most
  assign norm = top_set ? product : {product[fmul_pkg::PROD_BITS-2:0], 1'b0};

  // ========================================================================
  // Product register
  // ========================================================================

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_guard <= 1'b0;
      o_sticky <= 1'b0;
    end else if (i_load) begin
      // First bit below the kept mantissa
      o_guard <= norm[fmul_pkg::PROD_BITS-fmul_pkg::MANT_BITS-1];
      // Everything further down collapses into sticky
      o_sticky <= |norm[fmul_pkg::PROD_BITS-fmul_pkg::MANT_BITS-2:0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      o_mant <= norm[fmul_pkg::PROD_BITS-1-:fmul_pkg::MANT_BITS];
      // Exponent goes up by one when the product reached 2.0
      o_exp <= top_set ? i_exp + fmul_pkg::sexp_t'(1) : i_exp;
    end
  end

endmodule

//--- src/fmul_decode.sv
module fmul_decode (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_load,
  input  fmul_pkg::fp_t   i_op_a,
  input  fmul_pkg::fp_t   i_op_b,
  output logic            o_sign,
  output fmul_pkg::sexp_t o_exp,
  output fmul_pkg::mant_t o_mant_a,
  output fmul_pkg::mant_t o_mant_b,
  output logic            o_special,
  output fmul_pkg::fp_t   o_special_result,
  output logic            o_special_invalid
);

  // Returns {zero, inf, qnan, snan}
  // Subnormals land in zero since they are flushed
  function automatic logic [3:0] classify(input fmul_pkg::fp_t op);
    fmul_pkg::exp_t  op_exp;
    fmul_pkg::frac_t op_frac;
    logic            all_ones;
    op_exp = op[fmul_pkg::FRAC_BITS+:fmul_pkg::EXP_BITS];
    op_frac = op[fmul_pkg::FRAC_BITS-1:0];
    all_ones = (op_exp == fmul_pkg::EXP_MAX);
    classify[3] = (op_exp == '0);
    classify[2] = all_ones && (op_frac == '0);
    // Top fraction bit set marks a quiet NaN
    classify[1] = all_ones && op_frac[fmul_pkg::FRAC_BITS-1];
    classify[0] = all_ones && !op_frac[fmul_pkg::FRAC_BITS-1] && (op_frac != '0);
  endfunction

  logic [3:0]      cls_a;
  logic [3:0]      cls_b;
  logic            zero_a, inf_a, nan_a, snan_a;
  logic            zero_b, inf_b, nan_b, snan_b;
  logic            sign;
  fmul_pkg::sexp_t exp_sum;
  logic            special;
  fmul_pkg::fp_t   special_result;
  logic            special_invalid;

  assign cls_a = classify(i_op_a);
  assign cls_b = classify(i_op_b);

  assign zero_a = cls_a[3];
  assign inf_a = cls_a[2];
  assign nan_a = cls_a[1] | cls_a[0];
  assign snan_a = cls_a[0];
  assign zero_b = cls_b[3];
  assign inf_b = cls_b[2];
  assign nan_b = cls_b[1] | cls_b[0];
  assign snan_b = cls_b[0];

  assign sign = i_op_a[fmul_pkg::EXP_BITS+fmul_pkg::FRAC_BITS]
              ^ i_op_b[fmul_pkg::EXP_BITS+fmul_pkg::FRAC_BITS];

  // Biased sum minus one bias, can go negative for tiny products
  assign exp_sum =
    fmul_pkg::sexp_t'({2'b00, i_op_a[fmul_pkg::FRAC_BITS+:fmul_pkg::EXP_BITS]})
    + fmul_pkg::sexp_t'({2'b00, i_op_b[fmul_pkg::FRAC_BITS+:fmul_pkg::EXP_BITS]})
    - fmul_pkg::sexp_t'(fmul_pkg::EXP_BIAS);

  // Priority: NaN, inf times zero, inf, zero
  always_comb begin
    special = 1'b0;
    special_result = '0;
    special_invalid = 1'b0;
    if (nan_a || nan_b) begin
      special = 1'b1;
      special_result = fmul_pkg::CANONICAL_NAN;
      // Only a signaling NaN raises invalid
      special_invalid = snan_a || snan_b;
    end else if ((inf_a && zero_b) || (zero_a && inf_b)) begin
      special = 1'b1;
      special_result = fmul_pkg::CANONICAL_NAN;
      special_invalid = 1'b1;
    end else if (inf_a || inf_b) begin
      special = 1'b1;
      special_result = {sign, fmul_pkg::EXP_MAX, {fmul_pkg::FRAC_BITS{1'b0}}};
    end else if (zero_a || zero_b) begin
      special = 1'b1;
      special_result = {sign, {(fmul_pkg::EXP_BITS + fmul_pkg::FRAC_BITS){1'b0}}};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_special <= 1'b0;
      o_special_invalid <= 1'b0;
    end else if (i_load) begin
      o_special <= special;
      o_special_invalid <= special_invalid;
    end
  end

  // Hidden bit is always one here, zeros go down the special path
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      o_sign <= sign;
      o_exp <= exp_sum;
      o_mant_a <= {1'b1, i_op_a[fmul_pkg::FRAC_BITS-1:0]};
      o_mant_b <= {1'b1, i_op_b[fmul_pkg::FRAC_BITS-1:0]};
      o_special_result <= special_result;
    end
  end

endmodule

//--- src/fmul_pkg.sv
package fmul_pkg;

  // ========================================================================
  // Field widths
  // ========================================================================

  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned FRAC_BITS = 23;
  // Stored fraction plus the hidden bit
  localparam int unsigned MANT_BITS = 24;
  localparam int unsigned PROD_BITS = 48;
  // Two extra bits for exponent overflow and for going below zero
  localparam int unsigned SEXP_BITS = 10;

  localparam int unsigned EXP_BIAS = 127;

  // ========================================================================
  // Vector types
  // ========================================================================

  typedef logic [EXP_BITS+FRAC_BITS:0] fp_t;
  typedef logic [EXP_BITS-1:0] exp_t;
  typedef logic [FRAC_BITS-1:0] frac_t;
  typedef logic [MANT_BITS-1:0] mant_t;
  typedef logic [PROD_BITS-1:0] prod_t;
  typedef logic signed [SEXP_BITS-1:0] sexp_t;
  typedef logic [2:0] rm_t;
  // Order is invalid, overflow, underflow, inexact from the top bit down
  typedef logic [3:0] flags_t;

  // ========================================================================
  // Constants
  // ========================================================================

  // Exponent of infinity and NaN
  localparam exp_t EXP_MAX = '1;

  // Positive quiet NaN, only the top fraction bit set
  localparam fp_t CANONICAL_NAN = {1'b0, EXP_MAX, 1'b1, {(FRAC_BITS - 1){1'b0}}};

  // Rounding modes, codes 5 to 7 are handled like RNE
  localparam rm_t RM_RNE = 3'd0;
  localparam rm_t RM_RTZ = 3'd1;
  localparam rm_t RM_RDN = 3'd2;
  localparam rm_t RM_RUP = 3'd3;
  localparam rm_t RM_RMM = 3'd4;

  // Bit positions inside flags_t
  localparam int unsigned FLAG_NV = 3;
  localparam int unsigned FLAG_OF = 2;
  localparam int unsigned FLAG_UF = 1;
  localparam int unsigned FLAG_NX = 0;

endpackage
